// File: src/dcore_defines.svh
`ifndef DCORE_DEFINES_SVH
`define DCORE_DEFINES_SVH

// interleaved lanes delivered per clk_adc cycle
`define NTI 4

// ADC magnitude width, sign travels separately
`define NADC 7

// unfolded signed code, magnitude plus sign
`define NCODE (`NADC + 1)

// calibration window is 2**AVG_LOG2 cycles
`define AVG_LOG2 4

// PRBS7, taps at 7 and 6 bits back in serial order
`define NPRBS 7
`define NPRBS_TAP 6

// error and bit counters
`define NCNT 32

`endif

// File: src/dcore_pkg.sv
`default_nettype none

`include "dcore_defines.svh"

package dcore_pkg;

    // raw ADC sample as delivered by one lane
    typedef struct packed {
        logic              sign;
        logic [`NADC-1:0]  mag;
    } adc_lane_t;

    typedef adc_lane_t [`NTI-1:0] adc_word_t;

    typedef logic signed [`NCODE-1:0] code_t;
    typedef code_t [`NTI-1:0] code_word_t;

    // lane 0 is the earliest bit in serial order
    typedef logic [`NTI-1:0] lane_bits_t;

    typedef logic [`NCNT-1:0] count_t;

    // ext_offset applies only while en_cal is low
    typedef struct packed {
        logic       en_cal;
        code_word_t ext_offset;
    } cal_cfg_t;

    typedef struct packed {
        logic  sel_bist;
        code_t thresh;
    } slice_cfg_t;

    typedef struct packed {
        logic [`NPRBS-1:0] init_val;
        logic              inj_err;
    } gen_cfg_t;

    // clr wins over cke
    typedef struct packed {
        logic cke;
        logic clr;
    } chk_cfg_t;

endpackage

`default_nettype wire

// File: src/adc_unfold.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcore_defines.svh"

module adc_unfold (
    input  wire logic                   clk_adc,
    input  wire logic                   rst_n_i,
    input  wire dcore_pkg::adc_word_t   adc_i,
    input  wire dcore_pkg::cal_cfg_t    cal_cfg_i,
    output      dcore_pkg::code_word_t  code_o
);
    import dcore_pkg::*;

    localparam int NDIFF    = `NCODE + 1;
    localparam int NACC     = `NCODE + `AVG_LOG2;
    localparam int CODE_MAX = 2 ** (`NCODE - 1) - 1;
    localparam int CODE_MIN = -(2 ** (`NCODE - 1));

    code_t                   mag_ext [`NTI];
    code_t                   unf     [`NTI];
    code_t                   off_eff [`NTI];
    code_t                   off_q   [`NTI];
    logic signed [NDIFF-1:0] diff    [`NTI];
    logic signed [NACC-1:0]  acc_q   [`NTI];
    logic signed [NACC-1:0]  acc_nxt [`NTI];
    logic signed [NACC-1:0]  avg     [`NTI];
    code_word_t              code_nxt;

    logic [`AVG_LOG2-1:0]    win_q;
    logic                    win_last;

    // last cycle of the averaging window
    assign win_last = &win_q;

    always_comb begin
        for (int i = 0; i < `NTI; i++) begin
            // sign set means positive
            mag_ext[i] = {1'b0, adc_i[i].mag};
            unf[i]     = adc_i[i].sign ? mag_ext[i] : -mag_ext[i];

            // external offset bypasses the register so it lands on the next edge
            off_eff[i] = cal_cfg_i.en_cal ? off_q[i] : cal_cfg_i.ext_offset[i];
            diff[i]    = unf[i] - off_eff[i];

            if (diff[i] > CODE_MAX) begin
                code_nxt[i] = code_t'(CODE_MAX);
            end else if (diff[i] < CODE_MIN) begin
                code_nxt[i] = code_t'(CODE_MIN);
            end else begin
                code_nxt[i] = diff[i][`NCODE-1:0];
            end

            // running sum includes the current sample
            acc_nxt[i] = acc_q[i] + unf[i];
            avg[i]     = acc_nxt[i] >>> `AVG_LOG2;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            code_o <= '0;
            win_q  <= '0;
            for (int i = 0; i < `NTI; i++) begin
                off_q[i] <= '0;
                acc_q[i] <= '0;
            end
        end else begin
            code_o <= code_nxt;
            if (cal_cfg_i.en_cal) begin
                win_q <= win_q + 1'b1;
                for (int i = 0; i < `NTI; i++) begin
                    if (win_last) begin
                        off_q[i] <= avg[i][`NCODE-1:0];
                        acc_q[i] <= '0;
                    end else begin
                        acc_q[i] <= acc_nxt[i];
                    end
                end
            end else begin
                // idle window, offset tracks the external value
                win_q <= '0;
                for (int i = 0; i < `NTI; i++) begin
                    off_q[i] <= cal_cfg_i.ext_offset[i];
                    acc_q[i] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/prbs_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcore_defines.svh"

module prbs_gen (
    input  wire logic                  clk_adc,
    input  wire logic                  rst_n_i,
    input  wire dcore_pkg::gen_cfg_t   gen_cfg_i,
    output      dcore_pkg::lane_bits_t bits_o
);

    localparam int NSEQ = `NPRBS + `NTI;

    // state_q[0] is the oldest bit of the history
    logic [`NPRBS-1:0] state_q;
    logic [NSEQ-1:0]   seq;
    logic [`NTI-1:0]   flip;

    // unroll NTI serial steps of the Fibonacci LFSR
    always_comb begin
        seq = {{`NTI{1'b0}}, state_q};
        for (int i = 0; i < `NTI; i++) begin
            seq[`NPRBS + i] = seq[i] ^ seq[i + `NPRBS - `NPRBS_TAP];
        end
    end

    // error injection touches lane 0 of the output only
    always_comb begin
        flip    = '0;
        flip[0] = gen_cfg_i.inj_err;
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            state_q <= gen_cfg_i.init_val;
            bits_o  <= '0;
        end else begin
            // keep the newest NPRBS bits as next history
            state_q <= seq[`NTI +: `NPRBS];
            bits_o  <= seq[`NPRBS +: `NTI] ^ flip;
        end
    end

endmodule

`default_nettype wire

// File: src/bit_slicer.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcore_defines.svh"

module bit_slicer (
    input  wire logic                    clk_adc,
    input  wire logic                    rst_n_i,
    input  wire dcore_pkg::code_word_t   code_i,
    input  wire dcore_pkg::lane_bits_t   bist_i,
    input  wire dcore_pkg::slice_cfg_t   slice_cfg_i,
    output      dcore_pkg::lane_bits_t   bits_o
);
    import dcore_pkg::*;

    code_t      lane_code [`NTI];
    lane_bits_t dec;
    lane_bits_t bits_nxt;

    // signed compare per lane, equal to thresh decides zero
    always_comb begin
        for (int i = 0; i < `NTI; i++) begin
            lane_code[i] = code_i[i];
            dec[i]       = lane_code[i] > slice_cfg_i.thresh;
        end
    end

    // self-test bits bypass the comparator
    assign bits_nxt = slice_cfg_i.sel_bist ? bist_i : dec;

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= bits_nxt;
        end
    end

endmodule

`default_nettype wire

// File: src/prbs_check.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcore_defines.svh"

module prbs_check (
    input  wire logic                  clk_adc,
    input  wire logic                  rst_n_i,
    input  wire dcore_pkg::lane_bits_t bits_i,
    input  wire dcore_pkg::chk_cfg_t   chk_cfg_i,
    output      dcore_pkg::count_t     err_count_o,
    output      dcore_pkg::count_t     total_count_o
);
    import dcore_pkg::*;

    localparam int NSEQ = `NPRBS + `NTI;
    localparam int NERR = $clog2(`NTI + 1);

    // received history, hist_q[0] oldest
    logic [`NPRBS-1:0] hist_q;
    logic [NSEQ-1:0]   seq;
    logic [`NTI-1:0]   err;
    logic [NERR-1:0]   n_err;

    // history followed by the new word in serial order
    assign seq = {bits_i, hist_q};

    // predict each lane from the seven bits before it
    always_comb begin
        n_err = '0;
        for (int i = 0; i < `NTI; i++) begin
            err[i] = bits_i[i] ^ seq[i] ^ seq[i + `NPRBS - `NPRBS_TAP];
            n_err  = n_err + NERR'(err[i]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            hist_q <= '0;
        end else begin
            // self-synchronizing, history always follows the line
            hist_q <= seq[`NTI +: `NPRBS];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (chk_cfg_i.clr) begin
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (chk_cfg_i.cke) begin
            err_count_o   <= err_count_o + count_t'(n_err);
            total_count_o <= total_count_o + count_t'(`NTI);
        end
    end

endmodule

`default_nettype wire

// File: src/rx_dcore_top.sv
`timescale 1ns/1ns
`default_nettype none

module rx_dcore_top (
    input  wire logic                    clk_adc,
    input  wire logic                    rst_n_i,
    input  wire dcore_pkg::adc_word_t    adc_i,
    input  wire dcore_pkg::cal_cfg_t     cal_cfg_i,
    input  wire dcore_pkg::slice_cfg_t   slice_cfg_i,
    input  wire dcore_pkg::gen_cfg_t     gen_cfg_i,
    input  wire dcore_pkg::chk_cfg_t     chk_cfg_i,
    output wire dcore_pkg::code_word_t   dump_data_o,
    output wire dcore_pkg::count_t       err_count_o,
    output wire dcore_pkg::count_t       total_count_o
);
    import dcore_pkg::*;

    wire code_word_t codes;
    wire lane_bits_t bist_bits;
    wire lane_bits_t rx_bits;

    // unfolded codes double as the capture dump
    assign dump_data_o = codes;

    // stage 1, unfold and offset removal
    adc_unfold unfold_i (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .adc_i     (adc_i),
        .cal_cfg_i (cal_cfg_i),
        .code_o    (codes)
    );

    // self-test source
    prbs_gen prbs_gen_i (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .gen_cfg_i (gen_cfg_i),
        .bits_o    (bist_bits)
    );

    // stage 2, decisions
    bit_slicer slicer_i (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .code_i      (codes),
        .bist_i      (bist_bits),
        .slice_cfg_i (slice_cfg_i),
        .bits_o      (rx_bits)
    );

    // stage 3, error counting
    prbs_check prbs_check_i (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n_i),
        .bits_i        (rx_bits),
        .chk_cfg_i     (chk_cfg_i),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

`default_nettype wire

// File: dv/rx_dcore_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcore_defines.svh"

module rx_dcore_sva (
    input  wire logic                clk_adc,
    input  wire logic                rst_n_i,
    input  wire dcore_pkg::chk_cfg_t chk_cfg_i,
    input  wire dcore_pkg::count_t   err_count_o,
    input  wire dcore_pkg::count_t   total_count_o
);
    import dcore_pkg::*;

    // failed assertions, read back by the testbench
    int unsigned fail_count = 0;

    // previous edge counted normally, no reset and no clear
    property p_no_decrease;
        @(posedge clk_adc) disable iff (!rst_n_i)
        ($past(rst_n_i) && !$past(chk_cfg_i.clr)) |->
            (err_count_o >= $past(err_count_o)) &&
            (total_count_o >= $past(total_count_o));
    endproperty

    property p_err_step;
        @(posedge clk_adc) disable iff (!rst_n_i)
        ($past(rst_n_i) && !$past(chk_cfg_i.clr)) |->
            err_count_o <= $past(err_count_o) + count_t'(`NTI);
    endproperty

    // total moves by a full word or not at all
    property p_total_step;
        @(posedge clk_adc) disable iff (!rst_n_i)
        ($past(rst_n_i) && !$past(chk_cfg_i.clr)) |->
            total_count_o == $past(total_count_o) +
                ($past(chk_cfg_i.cke) ? count_t'(`NTI) : count_t'(0));
    endproperty

    a_no_decrease: assert property (p_no_decrease) else begin
        fail_count++;
        $error("counter decreased without clr or reset");
    end

    a_err_step: assert property (p_err_step) else begin
        fail_count++;
        $error("err_count_o rose by more than one word of lanes");
    end

    a_total_step: assert property (p_total_step) else begin
        fail_count++;
        $error("total_count_o step does not match cke");
    end

endmodule

bind prbs_check rx_dcore_sva sva_i (
    .clk_adc       (clk_adc),
    .rst_n_i       (rst_n_i),
    .chk_cfg_i     (chk_cfg_i),
    .err_count_o   (err_count_o),
    .total_count_o (total_count_o)
);

`default_nettype wire

// File: dv/tb_rx_dcore.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcore_defines.svh"

module tb_rx_dcore;
    import dcore_pkg::*;

    localparam int NROWS       = 7;
    localparam int MAX_ROW_CYC = 80;
    localparam int CLK_NS      = 40;
    localparam int SETTLE      = 4;
    localparam int INJ_FIRST   = 4;
    localparam int INJ_GAP     = 8;
    localparam int CODE_MAX    = (1 << (`NCODE - 1)) - 1;
    localparam int CODE_MIN    = -(1 << (`NCODE - 1));
    localparam int WATCHDOG_NS = (3 + NROWS * MAX_ROW_CYC) * CLK_NS + 1000;

    localparam logic [2:0] K_EXT  = 3'd0;
    localparam logic [2:0] K_CAL  = 3'd1;
    localparam logic [2:0] K_BIST = 3'd2;
    localparam logic [2:0] K_ADC  = 3'd3;
    localparam logic [2:0] K_CLR  = 3'd4;

    // lane_val is the offset for K_EXT and the constant code for K_CAL
    typedef struct packed {
        logic [2:0] kind;
        code_word_t lane_val;
        logic [7:0] n_cyc;
        logic [3:0] n_inj;
        count_t     exp_err;
    } test_row_t;

    logic        clk_adc;
    logic        rst_n_i;
    adc_word_t   adc;
    cal_cfg_t    cal_cfg;
    slice_cfg_t  slice_cfg;
    gen_cfg_t    gen_cfg;
    chk_cfg_t    chk_cfg;
    code_word_t  dump_data;
    count_t      err_count;
    count_t      total_count;

    test_row_t         rows     [NROWS];
    string             row_name [NROWS];
    logic [`NPRBS-1:0] ref_hist;
    int                code_errs;
    int                count_errs;
    int                sva_errs;

    rx_dcore_top dut_i (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n_i),
        .adc_i         (adc),
        .cal_cfg_i     (cal_cfg),
        .slice_cfg_i   (slice_cfg),
        .gen_cfg_i     (gen_cfg),
        .chk_cfg_i     (chk_cfg),
        .dump_data_o   (dump_data),
        .err_count_o   (err_count),
        .total_count_o (total_count)
    );

    always #(CLK_NS / 2) clk_adc = ~clk_adc;

    task automatic check_code(input string name, input code_word_t exp_val,
                              input code_word_t act_val);
        if (act_val !== exp_val) begin
            code_errs++;
            $display("error %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic check_count(input string name, input string what,
                               input count_t exp_val, input count_t act_val);
        if (act_val !== exp_val) begin
            count_errs++;
            $display("error %s (%s): expected %0d, actual %0d", name, what, exp_val, act_val);
        end
    endtask

    // unfold with sign set as positive and clamp to the code range
    function automatic code_t expect_code(input adc_lane_t s, input code_t off);
        int v;
        v = s.sign ? int'(s.mag) : -int'(s.mag);
        v = v - int'(off);
        if (v > CODE_MAX) v = CODE_MAX;
        if (v < CODE_MIN) v = CODE_MIN;
        return code_t'(v);
    endfunction

    function automatic adc_lane_t code_to_lane(input code_t c);
        adc_lane_t s;
        s.sign = (c >= 0);
        s.mag  = (c >= 0) ? c[`NADC-1:0] : `NADC'(-c);
        return s;
    endfunction

    // one bit becomes a nonzero sample on the matching side of zero
    function automatic adc_lane_t bit_to_lane(input logic b);
        adc_lane_t s;
        s.sign = b;
        s.mag  = `NADC'(1 + ($urandom % ((1 << `NADC) - 1)));
        return s;
    endfunction

    // serial PRBS7 model with ref_hist[0] seven bits back
    task automatic next_prbs_word(output lane_bits_t word);
        logic nb;
        for (int i = 0; i < `NTI; i++) begin
            nb       = ref_hist[0] ^ ref_hist[1];
            word[i]  = nb;
            ref_hist = {nb, ref_hist[`NPRBS-1:1]};
        end
    endtask

    task automatic fill_table();
        row_name[0] = "ext_offset";
        rows[0] = '{K_EXT, code_word_t'({8'sd20, -8'sd40, 8'sd5, -8'sd3}), 8'd24, 4'd0, 32'd0};
        row_name[1] = "ext_saturate";
        rows[1] = '{K_EXT, code_word_t'({8'sd127, -8'sd128, 8'sd100, -8'sd100}), 8'd24, 4'd0,
                    32'd0};
        // three full windows of 16 cycles
        row_name[2] = "cal_converge";
        rows[2] = '{K_CAL, code_word_t'({8'sd37, -8'sd90, 8'sd0, 8'sd127}), 8'd48, 4'd0, 32'd0};
        row_name[3] = "bist_clean";
        rows[3] = '{K_BIST, '0, 8'd40, 4'd0, 32'd0};
        // each flipped bit is seen as itself and as both taps
        row_name[4] = "bist_inject";
        rows[4] = '{K_BIST, '0, 8'd40, 4'd3, 32'd9};
        // follows the injected row so both counters hold nonzero values
        row_name[5] = "clear";
        rows[5] = '{K_CLR, '0, 8'd1, 4'd0, 32'd0};
        row_name[6] = "adc_prbs";
        rows[6] = '{K_ADC, '0, 8'd48, 4'd0, 32'd0};
    endtask

    task automatic run_ext_row(input int idx);
        adc_word_t  sent;
        code_word_t exp_val;
        for (int c = 0; c <= int'(rows[idx].n_cyc); c++) begin
            @(negedge clk_adc);
            if (c > 0) begin
                for (int i = 0; i < `NTI; i++) begin
                    exp_val[i] = expect_code(sent[i], rows[idx].lane_val[i]);
                end
                check_code(row_name[idx], exp_val, dump_data);
            end
            cal_cfg.en_cal     = 1'b0;
            cal_cfg.ext_offset = rows[idx].lane_val;
            sent = adc_word_t'($urandom);
            adc  = sent;
        end
    endtask

    task automatic run_cal_row(input int idx);
        for (int c = 0; c < int'(rows[idx].n_cyc) + 4; c++) begin
            @(negedge clk_adc);
            if (c > int'(rows[idx].n_cyc)) begin
                check_code(row_name[idx], '0, dump_data);
            end
            cal_cfg.en_cal     = 1'b1;
            cal_cfg.ext_offset = '0;
            for (int i = 0; i < `NTI; i++) begin
                adc[i] = code_to_lane(rows[idx].lane_val[i]);
            end
        end
    endtask

    // clear and settle, then count for n_cyc cycles and idle two more
    task automatic run_count_row(input int idx);
        int         n_cnt;
        int         span;
        lane_bits_t bits;
        n_cnt = rows[idx].n_cyc;
        for (int c = 0; c < n_cnt + SETTLE + 3; c++) begin
            @(negedge clk_adc);
            cal_cfg            = '0;
            slice_cfg.sel_bist = (rows[idx].kind == K_BIST);
            slice_cfg.thresh   = '0;
            chk_cfg.clr        = (c == 0);
            chk_cfg.cke        = (c > SETTLE) && (c <= SETTLE + n_cnt);
            span               = c - SETTLE - 1;
            gen_cfg.inj_err    = (span >= INJ_FIRST) && ((span - INJ_FIRST) % INJ_GAP == 0) &&
                                 ((span - INJ_FIRST) / INJ_GAP < int'(rows[idx].n_inj));
            if (rows[idx].kind == K_ADC) begin
                next_prbs_word(bits);
                for (int i = 0; i < `NTI; i++) begin
                    adc[i] = bit_to_lane(bits[i]);
                end
            end
        end
        check_count(row_name[idx], "errors", rows[idx].exp_err, err_count);
        check_count(row_name[idx], "bits", count_t'(`NTI * n_cnt), total_count);
    endtask

    task automatic run_clr_row(input int idx);
        @(negedge clk_adc);
        if ((err_count == '0) || (total_count == '0)) begin
            count_errs++;
            $display("counters were not both nonzero before the clear test, nothing to clear");
        end
        // clr must win over cke
        chk_cfg.clr = 1'b1;
        chk_cfg.cke = 1'b1;
        @(negedge clk_adc);
        check_count(row_name[idx], "errors", '0, err_count);
        check_count(row_name[idx], "bits", '0, total_count);
        chk_cfg = '0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out before all test rows finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        clk_adc          = 1'b0;
        rst_n_i          = 1'b0;
        adc              = '0;
        cal_cfg          = '0;
        slice_cfg        = '0;
        gen_cfg          = '0;
        gen_cfg.init_val = 7'h5b;
        chk_cfg          = '0;
        code_errs        = 0;
        count_errs       = 0;
        ref_hist         = 7'h2d;
        void'($urandom(32'h3aae));
        fill_table();
        repeat (3) @(negedge clk_adc);
        rst_n_i = 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            case (rows[r].kind)
                K_EXT:   run_ext_row(r);
                K_CAL:   run_cal_row(r);
                K_CLR:   run_clr_row(r);
                default: run_count_row(r);
            endcase
        end
        sva_errs = dut_i.prbs_check_i.sva_i.fail_count;
        $display("code errors: %0d, count errors: %0d, assertion failures: %0d",
                 code_errs, count_errs, sva_errs);
        if (code_errs + count_errs + sva_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/dcore_pkg.sv
src/adc_unfold.sv
src/prbs_gen.sv
src/bit_slicer.sv
src/prbs_check.sv
src/rx_dcore_top.sv
dv/rx_dcore_sva.sv
dv/tb_rx_dcore.sv
